// ==== cache_params.svh ====
// Cache geometry and bus width macros, included by the package and the RTL modules
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ==============================
// Cache geometry
// ==============================
`define CACHE_SETS   8     // Direct mapped, one line per set
`define INDEX_BITS   3
`define OFFSET_BITS  5     // Byte offset in a 32-byte line
`define TAG_BITS     24

// ==============================
// Line and memory bus
// ==============================
`define LINE_BITS    256
`define BURST_BITS   64
`define BURST_COUNT  4     // Beats per line

`endif

// ==== cache_pkg.sv ====
// Shared cache types and FSM state encodings, imported by the interface and the RTL
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [31:0]           word_t;
    typedef logic [`TAG_BITS-1:0]  tag_t;

    // Cache controller FSM
    typedef enum logic [2:0]
    {
        IDLE,
        COMPARE,
        WRITEBACK,
        ALLOCATE,
        REFILL_DONE
    } cache_state_e;

    // Line adaptor FSM, prefixed to keep apart from controller states
    typedef enum logic [1:0]
    {
        ADP_IDLE,
        ADP_READ_BEAT,
        ADP_WRITE_BEAT,
        ADP_DONE
    } adaptor_state_e;

endpackage : cache_pkg

// ==== line_if.sv ====
// Line transfer interface between the cache controller and the cacheline adaptor
interface line_if;
    import cache_pkg::*;

    line_t       line_to_mem;    // Victim line for write-back
    line_t       line_from_mem;  // Assembled fill line
    logic [31:0] line_address;   // Line aligned
    logic        line_read;
    logic        line_write;
    logic        line_resp;      // One-cycle pulse

    modport controller
    (
        output line_to_mem,
        output line_address,
        output line_read,
        output line_write,
        input  line_from_mem,
        input  line_resp
    );

    modport adaptor
    (
        input  line_to_mem,
        input  line_address,
        input  line_read,
        input  line_write,
        output line_from_mem,
        output line_resp
    );

endinterface : line_if

// ==== cache_array.sv ====
// Tag, valid, dirty and line storage for the direct-mapped cache, read by index, written per entry
`include "cache_params.svh"

module cache_array
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Lookup
    input  logic [`INDEX_BITS-1:0]  index_i,
    output cache_pkg::tag_t         tag_o,
    output logic                    valid_o,
    output logic                    dirty_o,
    output cache_pkg::line_t        line_o,

    // Update
    input  logic                    line_we_i,
    input  cache_pkg::line_t        line_i,
    input  cache_pkg::tag_t         tag_i,
    input  logic                    dirty_i
);
    import cache_pkg::*;

    tag_t                   tag_mem   [`CACHE_SETS];
    line_t                  line_mem  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_SETS-1:0] dirty_q;

    // ==============================
    // Combinational lookup
    // ==============================
    assign tag_o   = tag_mem[index_i];
    assign line_o  = line_mem[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];

    // ==============================
    // Entry update
    // ==============================
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_q <= '0;
        end
        else if (line_we_i)
        begin
            valid_q[index_i] <= 1'b1;   // Any write installs a live entry
        end
    end

    // Dirty bit only matters while valid
    always_ff @(posedge clk)
    begin
        if (line_we_i)
        begin
            dirty_q[index_i] <= dirty_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (line_we_i)
        begin
            tag_mem[index_i]  <= tag_i;
            line_mem[index_i] <= line_i;
        end
    end

endmodule : cache_array

// ==== cache_control.sv ====
// Cache controller FSM for hit, dirty write-back and allocate, with word select and byte merge
`include "cache_params.svh"

module cache_control
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Processor side
    input  logic [31:0]             mem_address_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  logic [3:0]              mem_byte_enable_i,
    input  cache_pkg::word_t        mem_wdata_i,
    output cache_pkg::word_t        mem_rdata_o,
    output logic                    mem_resp_o,

    // Array lookup
    output logic [`INDEX_BITS-1:0]  index_o,
    input  cache_pkg::tag_t         tag_i,
    input  logic                    valid_i,
    input  logic                    dirty_i,
    input  cache_pkg::line_t        line_i,

    // Array update
    output logic                    line_we_o,
    output cache_pkg::line_t        line_o,
    output cache_pkg::tag_t         tag_o,
    output logic                    dirty_o,

    line_if.controller              line_bus
);
    import cache_pkg::*;

    cache_state_e              state_q;
    cache_state_e              state_d;
    tag_t                      addr_tag;
    logic [`OFFSET_BITS-3:0]   word_sel;
    logic                      hit;
    word_t                     cur_word;
    word_t                     merged_word;
    line_t                     merged_line;

    // ==============================
    // Address decode and lookup
    // ==============================
    assign addr_tag = mem_address_i[31 -: `TAG_BITS];
    assign index_o  = mem_address_i[`OFFSET_BITS +: `INDEX_BITS];
    assign word_sel = mem_address_i[`OFFSET_BITS-1:2];
    assign hit      = valid_i && (tag_i == addr_tag);

    assign cur_word    = line_i[{word_sel, 5'b0} +: 32];
    assign mem_rdata_o = cur_word;

    // Byte merge for write hits
    always_comb
    begin
        merged_word = cur_word;
        for (int b = 0; b < 4; b++)
        begin
            if (mem_byte_enable_i[b])
                merged_word[8*b +: 8] = mem_wdata_i[8*b +: 8];
        end
        merged_line = line_i;
        merged_line[{word_sel, 5'b0} +: 32] = merged_word;
    end

    // Victim goes back to its own address
    assign line_bus.line_to_mem  = line_i;
    assign line_bus.line_address = (state_q == WRITEBACK) ?
                                   {tag_i, index_o, {`OFFSET_BITS{1'b0}}} :
                                   {addr_tag, index_o, {`OFFSET_BITS{1'b0}}};
    assign line_bus.line_write   = (state_q == WRITEBACK);
    assign line_bus.line_read    = (state_q == ALLOCATE);

    // ==============================
    // Controller FSM
    // ==============================
    always_comb
    begin
        state_d    = state_q;
        mem_resp_o = 1'b0;
        line_we_o  = 1'b0;
        line_o     = merged_line;
        tag_o      = addr_tag;
        dirty_o    = 1'b1;
        unique case (state_q)
            IDLE:
            begin
                if (mem_read_i || mem_write_i)
                    state_d = COMPARE;
            end
            COMPARE:
            begin
                if (hit)
                begin
                    mem_resp_o = 1'b1;
                    line_we_o  = mem_write_i;
                    state_d    = IDLE;
                end
                else if (valid_i && dirty_i)
                    state_d = WRITEBACK;
                else
                    state_d = ALLOCATE;
            end
            WRITEBACK:
            begin
                if (line_bus.line_resp)
                    state_d = ALLOCATE;
            end
            ALLOCATE:
            begin
                if (line_bus.line_resp)
                    state_d = REFILL_DONE;
            end
            REFILL_DONE:
            begin
                line_we_o = 1'b1;                     // Install fill line clean
                line_o    = line_bus.line_from_mem;
                dirty_o   = 1'b0;
                state_d   = COMPARE;                  // Replay the access as a hit
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

endmodule : cache_control

// ==== cacheline_adaptor.sv ====
// Line-to-burst adaptor, splits a 256-bit line into four 64-bit beats and assembles fills
`include "cache_params.svh"

module cacheline_adaptor
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Controller side
    line_if.adaptor                 line_bus,

    // Memory side
    input  logic [`BURST_BITS-1:0]  pmem_burst_i,
    output logic [`BURST_BITS-1:0]  pmem_burst_o,
    output logic [31:0]             pmem_address_o,
    output logic                    pmem_read_o,
    output logic                    pmem_write_o,
    input  logic                    pmem_resp_i
);
    import cache_pkg::*;

    adaptor_state_e state_q;
    adaptor_state_e state_d;
    logic [1:0]     beat_q;
    logic [31:0]    addr_q;
    line_t          wline_q;
    line_t          rline_q;
    logic           start;
    logic           last_beat;

    assign start     = (state_q == ADP_IDLE) && (line_bus.line_read || line_bus.line_write);
    assign last_beat = (beat_q == 2'(`BURST_COUNT - 1));

    // ==============================
    // Transfer FSM
    // ==============================
    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            ADP_IDLE:
            begin
                if (line_bus.line_read)
                    state_d = ADP_READ_BEAT;
                else if (line_bus.line_write)
                    state_d = ADP_WRITE_BEAT;
            end
            ADP_READ_BEAT, ADP_WRITE_BEAT:
            begin
                if (pmem_resp_i && last_beat)
                    state_d = ADP_DONE;
            end
            ADP_DONE:
            begin
                state_d = ADP_IDLE;
            end
            default:
            begin
                state_d = ADP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state_q <= ADP_IDLE;
            beat_q  <= 2'd0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == ADP_IDLE)
                beat_q <= 2'd0;
            else if (pmem_resp_i)
                beat_q <= beat_q + 2'd1;   // Wraps after the last beat
        end
    end

    // ==============================
    // Address, write line and fill line
    // ==============================
    always_ff @(posedge clk)
    begin
        if (start)
            addr_q <= line_bus.line_address;
        if (start && line_bus.line_write)
            wline_q <= line_bus.line_to_mem;
        if ((state_q == ADP_READ_BEAT) && pmem_resp_i)
            rline_q[{beat_q, 6'b0} +: `BURST_BITS] <= pmem_burst_i;   // Beat 0 is bits 63:0
    end

    assign pmem_address_o = addr_q;
    assign pmem_read_o    = (state_q == ADP_READ_BEAT);
    assign pmem_write_o   = (state_q == ADP_WRITE_BEAT);
    assign pmem_burst_o   = wline_q[{beat_q, 6'b0} +: `BURST_BITS];

    assign line_bus.line_from_mem = rline_q;
    assign line_bus.line_resp     = (state_q == ADP_DONE);

endmodule : cacheline_adaptor

// ==== cache_top.sv ====
// Data cache top level, connects the array, the controller and the burst adaptor
`include "cache_params.svh"

module cache_top
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Processor side
    input  logic [31:0]             mem_address_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  logic [3:0]              mem_byte_enable_i,
    input  cache_pkg::word_t        mem_wdata_i,
    output cache_pkg::word_t        mem_rdata_o,
    output logic                    mem_resp_o,

    // Burst memory side
    input  logic [`BURST_BITS-1:0]  pmem_burst_i,
    output logic [`BURST_BITS-1:0]  pmem_burst_o,
    output logic [31:0]             pmem_address_o,
    output logic                    pmem_read_o,
    output logic                    pmem_write_o,
    input  logic                    pmem_resp_i
);
    import cache_pkg::*;

    logic [`INDEX_BITS-1:0] index;
    tag_t                   rd_tag;
    logic                   rd_valid;
    logic                   rd_dirty;
    line_t                  rd_line;
    logic                   wr_en;
    line_t                  wr_line;
    tag_t                   wr_tag;
    logic                   wr_dirty;

    line_if line_bus ();

    cache_array array_i
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .index_i   (index),
        .tag_o     (rd_tag),
        .valid_o   (rd_valid),
        .dirty_o   (rd_dirty),
        .line_o    (rd_line),
        .line_we_i (wr_en),
        .line_i    (wr_line),
        .tag_i     (wr_tag),
        .dirty_i   (wr_dirty)
    );

    cache_control control_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_address_i     (mem_address_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_resp_o        (mem_resp_o),
        .index_o           (index),
        .tag_i             (rd_tag),
        .valid_i           (rd_valid),
        .dirty_i           (rd_dirty),
        .line_i            (rd_line),
        .line_we_o         (wr_en),
        .line_o            (wr_line),
        .tag_o             (wr_tag),
        .dirty_o           (wr_dirty),
        .line_bus          (line_bus.controller)
    );

    cacheline_adaptor adaptor_i
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .line_bus       (line_bus.adaptor),
        .pmem_burst_i   (pmem_burst_i),
        .pmem_burst_o   (pmem_burst_o),
        .pmem_address_o (pmem_address_o),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .pmem_resp_i    (pmem_resp_i)
    );

endmodule : cache_top

// ==== tb_burst_mem.sv ====
// Behavioral burst memory for the cache testbench, serves line transfers with random wait states
`include "cache_params.svh"

module tb_burst_mem
#(
    parameter logic [31:0] FILL_XOR = 32'h0
)
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [31:0]             pmem_address_i,
    input  logic                    pmem_read_i,
    input  logic                    pmem_write_i,
    input  logic [`BURST_BITS-1:0]  pmem_burst_i,
    output logic [`BURST_BITS-1:0]  pmem_burst_o,
    output logic                    pmem_resp_o,
    input  logic [`LINE_BITS-1:0]   expect_line_i,   // Predicted victim line
    output logic                    error_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`LINE_BITS-1:0] lines [logic [31:0]];    // Only lines written back
    logic [31:0]           lfsr_q = 32'h70f2;

    function automatic logic next_random_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++)
            r = {r[30:0], next_random_bit()};
        return r;
    endfunction

    // Unwritten words hold their own address xor a constant
    function automatic logic [`LINE_BITS-1:0] stored_line(input logic [31:0] line_addr);
        logic [`LINE_BITS-1:0] l;
        if (lines.exists(line_addr))
            return lines[line_addr];
        for (int w = 0; w < `LINE_BITS / 32; w++)
            l[32*w +: 32] = (line_addr + 32'(4 * w)) ^ FILL_XOR;
        return l;
    endfunction

    task automatic raise_error(input string msg);
        $display("%s", msg);
        error_o = 1'b1;
    endtask

    // ==============================
    // One line transfer
    // ==============================
    task automatic serve_transfer();
        logic [31:0]           addr;
        logic                  is_write;
        logic [`LINE_BITS-1:0] line;
        logic [31:0]           wait_cycles;
        addr     = pmem_address_i;
        is_write = pmem_write_i;
        line     = stored_line(addr);
        assert (addr[`OFFSET_BITS-1:0] == '0 && !(pmem_read_i && pmem_write_i))
        else raise_error($sformatf("burst memory got a bad request at address %h", addr));
        for (int b = 0; b < `BURST_COUNT; b++)
        begin
            wait_cycles = random_bits(2);
            repeat (wait_cycles)
            begin
                @(posedge clk);
                #2 pmem_resp_o = 1'b0;
            end
            @(posedge clk);
            #2;
            pmem_resp_o  = 1'b1;
            pmem_burst_o = line[`BURST_BITS*b +: `BURST_BITS];
            @(negedge clk);
            assert (pmem_address_i === addr && (is_write ? pmem_write_i : pmem_read_i))
            else raise_error("burst memory saw the request change inside a transfer");
            if (is_write)
            begin
                assert (pmem_burst_i === expect_line_i[`BURST_BITS*b +: `BURST_BITS])
                else raise_error($sformatf("mismatch pmem_burst_o beat %0d at %h: got %h expected %h",
                    b, addr, pmem_burst_i, expect_line_i[`BURST_BITS*b +: `BURST_BITS]));
                line[`BURST_BITS*b +: `BURST_BITS] = pmem_burst_i;
            end
        end
        @(posedge clk);
        #2 pmem_resp_o = 1'b0;
        @(negedge clk);
        assert (!pmem_read_i && !pmem_write_i)
        else raise_error("burst memory request still held after the fourth beat");
        if (is_write)
            lines[addr] = line;
    endtask

    initial
    begin
        pmem_resp_o  = 1'b0;
        pmem_burst_o = '0;
        error_o      = 1'b0;
        forever
        begin
            @(negedge clk);
            if (reset_n && (pmem_read_i || pmem_write_i))
                serve_transfer();
        end
    end

endmodule : tb_burst_mem

// ==== tb_cache.sv ====
// Testbench top for the data cache, checks directed and random accesses against a shadow memory
`include "cache_params.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int                  CLK_PERIOD   = 40;
    localparam int                  NUM_RANDOM   = 64;
    localparam int                  NUM_REQUESTS = NUM_RANDOM + 7;
    localparam int                  WATCHDOG_NS  = (NUM_REQUESTS * 200 + 32) * CLK_PERIOD;
    localparam logic [31:0]         FILL_XOR     = 32'h5ac3_3c95;
    localparam logic [`TAG_BITS-1:0] TAG_A       = 24'h00_0012;
    localparam logic [`TAG_BITS-1:0] TAG_B       = 24'h00_0a47;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic [31:0]            mem_address;
    logic                   mem_read;
    logic                   mem_write;
    logic [3:0]             mem_be;
    logic [31:0]            mem_wdata;
    logic [31:0]            mem_rdata;
    logic                   mem_resp;
    logic [`BURST_BITS-1:0] burst_to_cache;
    logic [`BURST_BITS-1:0] burst_from_cache;
    logic [31:0]            pmem_address;
    logic                   pmem_read;
    logic                   pmem_write;
    logic                   pmem_resp;
    logic [`LINE_BITS-1:0]  wb_line;
    logic                   mem_error;

    // Shadow memory and the expected cache contents
    logic [31:0]            shadow [logic [31:0]];
    logic [`TAG_BITS-1:0]   res_tag [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] res_valid;
    logic [`CACHE_SETS-1:0] res_dirty;
    logic [31:0]            fetch_addr;
    logic [31:0]            wb_addr;
    int                     read_beats;
    int                     write_beats;
    int                     busy_cycles;
    logic [31:0]            lfsr_q = 32'h70f2;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top cache_top_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_address_i     (mem_address),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .mem_byte_enable_i (mem_be),
        .mem_wdata_i       (mem_wdata),
        .mem_rdata_o       (mem_rdata),
        .mem_resp_o        (mem_resp),
        .pmem_burst_i      (burst_to_cache),
        .pmem_burst_o      (burst_from_cache),
        .pmem_address_o    (pmem_address),
        .pmem_read_o       (pmem_read),
        .pmem_write_o      (pmem_write),
        .pmem_resp_i       (pmem_resp)
    );

    tb_burst_mem #(.FILL_XOR(FILL_XOR)) mem_i
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .pmem_address_i (pmem_address),
        .pmem_read_i    (pmem_read),
        .pmem_write_i   (pmem_write),
        .pmem_burst_i   (burst_from_cache),
        .pmem_burst_o   (burst_to_cache),
        .pmem_resp_o    (pmem_resp),
        .expect_line_i  (wb_line),
        .error_o        (mem_error)
    );

    function automatic logic next_random_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++)
            r = {r[30:0], next_random_bit()};
        return r;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] word_addr);
        if (shadow.exists(word_addr))
            return shadow[word_addr];
        return word_addr ^ FILL_XOR;    // Same fill as the memory model
    endfunction

    function automatic logic [`LINE_BITS-1:0] shadow_line(input logic [31:0] line_addr);
        logic [`LINE_BITS-1:0] l;
        for (int w = 0; w < `LINE_BITS / 32; w++)
            l[32*w +: 32] = shadow_word(line_addr + 32'(4 * w));
        return l;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_quiet(input string when);
        assert (mem_resp === 1'b0 && pmem_read === 1'b0 && pmem_write === 1'b0)
        else report_failure($sformatf("mismatch %s: mem_resp_o %h pmem_read_o %h pmem_write_o %h",
            when, mem_resp, pmem_read, pmem_write));
    endtask

    // ==============================
    // Memory side monitor
    // ==============================
    always @(negedge clk)
    begin
        if (pmem_read || pmem_write)
            busy_cycles++;
        if (pmem_resp && pmem_read)
        begin
            read_beats++;
            assert (pmem_address === fetch_addr)
            else report_failure($sformatf("mismatch pmem_address_o on fill: got %h expected %h",
                pmem_address, fetch_addr));
        end
        if (pmem_resp && pmem_write)
        begin
            write_beats++;
            assert (pmem_address === wb_addr)
            else report_failure($sformatf("mismatch pmem_address_o on write-back: got %h expected %h",
                pmem_address, wb_addr));
            assert (read_beats == 0)
            else report_failure("write-back beat seen after the fill had already started");
        end
    end

    always @(posedge mem_error)
        report_failure("burst memory check failed");

    // ==============================
    // One processor access
    // ==============================
    task automatic do_access(input logic [31:0] addr, input logic write,
                             input logic [3:0] be, input logic [31:0] wdata);
        logic [31:0]            word_addr;
        logic [`INDEX_BITS-1:0] idx;
        logic [`TAG_BITS-1:0]   tag;
        logic                   expect_hit;
        logic                   expect_wb;
        logic [31:0]            expect_word;
        logic [31:0]            merged;
        int                     cycles;
        word_addr   = {addr[31:2], 2'b00};
        idx         = addr[`OFFSET_BITS +: `INDEX_BITS];
        tag         = addr[31 -: `TAG_BITS];
        expect_hit  = res_valid[idx] && (res_tag[idx] == tag);
        expect_wb   = !expect_hit && res_valid[idx] && res_dirty[idx];
        fetch_addr  = {tag, idx, {`OFFSET_BITS{1'b0}}};
        wb_addr     = {res_tag[idx], idx, {`OFFSET_BITS{1'b0}}};
        wb_line     = shadow_line(wb_addr);
        expect_word = shadow_word(word_addr);
        read_beats  = 0;
        write_beats = 0;
        busy_cycles = 0;

        @(posedge clk);
        #2;
        mem_address = addr;
        mem_read    = !write;
        mem_write   = write;
        mem_be      = be;
        mem_wdata   = wdata;
        cycles      = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (mem_resp !== 1'b1);

        if (expect_hit)
        begin
            assert (cycles == 2)
            else report_failure($sformatf("hit at %h answered after %0d cycles", addr, cycles));
            assert (busy_cycles == 0)
            else report_failure($sformatf("memory was requested on a hit at %h", addr));
        end
        else
        begin
            assert (read_beats == `BURST_COUNT)
            else report_failure($sformatf("miss at %h saw %0d fill beats", addr, read_beats));
            assert (write_beats == (expect_wb ? `BURST_COUNT : 0))
            else report_failure($sformatf("miss at %h saw %0d write-back beats", addr, write_beats));
        end
        if (!write)
        begin
            assert (mem_rdata === expect_word)
            else report_failure($sformatf("mismatch mem_rdata_o at %h: got %h expected %h",
                addr, mem_rdata, expect_word));
        end

        if (write)
        begin
            merged = expect_word;
            for (int b = 0; b < 4; b++)
            begin
                if (be[b])
                    merged[8*b +: 8] = wdata[8*b +: 8];
            end
            shadow[word_addr] = merged;
        end
        res_dirty[idx] = write || (expect_hit && res_dirty[idx]);
        res_valid[idx] = 1'b1;
        res_tag[idx]   = tag;

        @(posedge clk);
        #2;
        mem_read  = 1'b0;    // Dropped the cycle after the response
        mem_write = 1'b0;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before all requests completed");
    end

    initial
    begin
        logic [31:0] pick;
        logic [31:0] addr;
        reset_n     = 1'b0;
        mem_address = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_be      = '0;
        mem_wdata   = '0;
        res_valid   = '0;
        res_dirty   = '0;
        wb_line     = '0;
        for (int s = 0; s < `CACHE_SETS; s++)
            res_tag[s] = '0;

        repeat (16)
        begin
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        #2 reset_n = 1'b1;
        @(negedge clk);
        check_quiet("after reset");

        // ==============================
        // Directed accesses in set 0
        // ==============================
        do_access({TAG_A, 3'd0, 5'h0c}, 1'b0, 4'hf, 32'h0);            // Clean read miss
        do_access({TAG_A, 3'd0, 5'h14}, 1'b0, 4'hf, 32'h0);
        do_access({TAG_A, 3'd0, 5'h14}, 1'b1, 4'hf, 32'hcafe_0123);
        do_access({TAG_A, 3'd0, 5'h08}, 1'b1, 4'b0101, 32'h1122_3344); // Byte merge
        do_access({TAG_A, 3'd0, 5'h08}, 1'b0, 4'hf, 32'h0);
        do_access({TAG_B, 3'd0, 5'h08}, 1'b0, 4'hf, 32'h0);            // Evicts dirty A
        do_access({TAG_A, 3'd0, 5'h14}, 1'b0, 4'hf, 32'h0);            // A back from memory

        // Random mix over two tags per set
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            pick = random_bits(12);
            addr = {pick[1] ? TAG_B : TAG_A, pick[4:2], pick[7:5], 2'b00};
            do_access(addr, pick[0], pick[11:8], random_bits(32));
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_cache

// ==== filelist.f ====
+incdir+.
cache_pkg.sv
line_if.sv
cache_array.sv
cache_control.sv
cacheline_adaptor.sv
cache_top.sv
tb_burst_mem.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_cache
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
